// ==== hw/desc_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module desc_table import scene_pkg::*; #(
    parameter int ENTRIES = 256,
    parameter int ADDR_W  = 8
) (
    input  wire logic              sck,
    input  wire logic              rst,
    input  wire logic              we,
    input  wire buf_id_t           wid,
    input  wire logic [ADDR_W-1:0] wbase,
    input  wire count_t            wcount,
    input  wire buf_id_t           rid,
    output logic      [ADDR_W-1:0] base,
    output count_t                 count
);

    logic [ADDR_W-1:0] base_arr  [ENTRIES];
    count_t            count_arr [ENTRIES];

    // cleared table means every id reads as an empty buffer
    always_ff @(posedge sck) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                base_arr[i]  <= '0;
                count_arr[i] <= '0;
            end
        end else if (we && int'(wid) < ENTRIES) begin
            base_arr[wid]  <= wbase;
            count_arr[wid] <= wcount;
        end
    end

    always_comb begin
        if (int'(rid) < ENTRIES) begin
            base  = base_arr[rid];
            count = count_arr[rid];
        end else begin
            base  = '0;  // id beyond table
            count = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/scene_cmd_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_cmd_fsm import scene_pkg::*; #(
    parameter int MAX_VERT = 256,
    parameter int MAX_TRI  = 256
) (
    input  wire logic       sck,
    input  wire logic       rst,

    input  wire logic       opcode_valid,
    input  wire opcode_t    opcode,

    input  wire logic       vert_hdr_valid,
    input  wire vaddr_t     vert_base,
    input  wire count_t     vert_count,
    input  wire logic       vert_valid,
    input  wire vertex_t    vert_in,

    input  wire logic       tri_hdr_valid,
    input  wire taddr_t     tri_base,
    input  wire count_t     tri_count,
    input  wire logic       tri_valid,
    input  wire tri_t       tri_in,

    input  wire logic       inst_valid,
    input  wire inst_id_t   inst_id_in,
    input  wire inst_t      inst_in,
    input  wire transform_t transform_in,

    output logic            vert_we,
    output vaddr_t          vert_waddr,
    output vertex_t         vert_wdata,
    output logic            tri_we,
    output taddr_t          tri_waddr,
    output tri_t            tri_wdata,
    output logic            vdesc_we,
    output logic            tdesc_we,
    output logic            inst_we,
    output inst_t           inst_wdata,
    output inst_id_t        inst_raddr,  // also the instance write address
    input  wire inst_t      inst_rdata,
    output status_t         status,
    output logic            busy
);

    cmd_state_t state;

    // run registers, shared by vertex and triangle buffers
    vaddr_t     wr_base;
    count_t     wr_count;
    count_t     wr_idx;
    count_t     idx_next;
    vaddr_t     wr_addr;

    inst_id_t   upd_id;
    transform_t upd_trans;

    logic       hdr_fire;
    vaddr_t     hdr_base;
    count_t     hdr_count;
    logic [9:0] hdr_end;    // wide enough for 255 + 256
    logic [9:0] hdr_limit;
    logic       hdr_ovf;
    logic       item_fire;

    assign hdr_fire  = (state == VERT_HDR && vert_hdr_valid) ||
                       (state == TRI_HDR && tri_hdr_valid);
    assign hdr_base  = (state == TRI_HDR) ? tri_base : vert_base;
    assign hdr_count = (state == TRI_HDR) ? tri_count : vert_count;
    assign hdr_limit = (state == TRI_HDR) ? 10'(MAX_TRI) : 10'(MAX_VERT);
    assign hdr_end   = 10'(hdr_base) + 10'(hdr_count);
    assign hdr_ovf   = hdr_end > hdr_limit;

    assign idx_next  = wr_idx + 9'd1;
    assign wr_addr   = wr_base + vaddr_t'(wr_idx);  // in range after overflow check

    assign vert_we    = (state == VERT_DATA) && vert_valid;
    assign vert_waddr = wr_addr;
    assign vert_wdata = vert_in;
    assign tri_we     = (state == TRI_DATA) && tri_valid;
    assign tri_waddr  = wr_addr;
    assign tri_wdata  = tri_in;
    assign item_fire  = vert_we || tri_we;

    assign vdesc_we = (state == VERT_HDR) && vert_hdr_valid && !hdr_ovf;
    assign tdesc_we = (state == TRI_HDR) && tri_hdr_valid && !hdr_ovf;

    // update keeps the stored buffer ids in the low bits
    assign inst_we    = ((state == INST_WR) && inst_valid) || (state == UPD_WR);
    assign inst_wdata = (state == UPD_WR) ? {upd_trans, inst_rdata[2*BUF_W-1:0]} : inst_in;
    assign inst_raddr = (state == UPD_WR) ? upd_id : inst_id_in;

    assign busy = (state != IDLE);

    always_ff @(posedge sck) begin
        if (rst) begin
            state    <= IDLE;
            status   <= ST_OK;
            wr_base  <= '0;
            wr_count <= '0;
            wr_idx   <= '0;
        end else begin
            case (state)
                IDLE: if (opcode_valid) begin
                    case (opcode)
                        OP_WIPE: status <= ST_OK;  // no-op
                        OP_VERT: state  <= VERT_HDR;
                        OP_TRI:  state  <= TRI_HDR;
                        OP_INST: state  <= INST_WR;
                        OP_UPD:  state  <= UPD_RD;
                        default: status <= ST_BAD_OP;
                    endcase
                end
                VERT_HDR, TRI_HDR: if (hdr_fire) begin
                    wr_base  <= hdr_base;
                    wr_count <= hdr_count;
                    wr_idx   <= '0;
                    if (hdr_ovf) begin
                        status <= ST_OVERFLOW;
                        state  <= IDLE;
                    end else if (hdr_count == '0) begin
                        status <= ST_OK;  // empty buffer, descriptor only
                        state  <= IDLE;
                    end else begin
                        state <= (state == VERT_HDR) ? VERT_DATA : TRI_DATA;
                    end
                end
                VERT_DATA, TRI_DATA: if (item_fire) begin
                    wr_idx <= idx_next;
                    if (idx_next == wr_count) begin
                        status <= ST_OK;
                        state  <= IDLE;
                    end
                end
                INST_WR: if (inst_valid) begin
                    status <= ST_OK;
                    state  <= IDLE;
                end
                UPD_RD: if (inst_valid) begin
                    state <= UPD_WR;
                end
                UPD_WR: begin
                    status <= ST_OK;
                    state  <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge sck) begin
        if (state == UPD_RD && inst_valid) begin
            upd_id    <= inst_id_in;
            upd_trans <= transform_in;
        end
    end

endmodule

`default_nettype wire

// ==== hw/scene_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_mem import scene_pkg::*; #(
    parameter int MAX_VERT = 256,
    parameter int MAX_TRI  = 256,
    parameter int MAX_INST = 256,
    parameter int MAX_BUF  = 256
) (
    input  wire logic       sck,
    input  wire logic       rst,

    input  wire logic       opcode_valid,
    input  wire opcode_t    opcode,

    input  wire logic       vert_hdr_valid,
    input  wire buf_id_t    vert_id_in,
    input  wire vaddr_t     vert_base,
    input  wire count_t     vert_count,
    input  wire logic       vert_valid,
    input  wire vertex_t    vert_in,

    input  wire logic       tri_hdr_valid,
    input  wire buf_id_t    tri_id_in,
    input  wire taddr_t     tri_base,
    input  wire count_t     tri_count,
    input  wire logic       tri_valid,
    input  wire tri_t       tri_in,

    input  wire logic       inst_valid,
    input  wire inst_id_t   inst_id_in,
    input  wire inst_t      inst_in,
    input  wire transform_t transform_in,

    input  wire inst_id_t   inst_id_rd,
    input  wire vaddr_t     vert_addr_rd,
    input  wire taddr_t     tri_addr_rd,

    output status_t         status,
    output logic            busy,
    output vertex_t         vert_out,
    output tri_t            tri_out,
    output transform_t      transform_out,
    output vaddr_t          cur_vert_base,
    output count_t          cur_vert_count,
    output taddr_t          cur_tri_base,
    output count_t          cur_tri_count
);

    localparam int VA_W = $clog2(MAX_VERT);
    localparam int TA_W = $clog2(MAX_TRI);
    localparam int IA_W = $clog2(MAX_INST);

    logic     vert_we;
    vaddr_t   vert_waddr;
    vertex_t  vert_wdata;
    logic     tri_we;
    taddr_t   tri_waddr;
    tri_t     tri_wdata;
    logic     vdesc_we;
    logic     tdesc_we;
    logic     inst_we;
    inst_t    inst_wdata;
    inst_id_t inst_addr;
    inst_t    inst_rmw;     // port a, update path
    inst_t    inst_rd;      // port b, frame driver
    buf_id_t  rd_vert_id;
    buf_id_t  rd_tri_id;

    assign {transform_out, rd_vert_id, rd_tri_id} = inst_rd;

    scene_cmd_fsm #(.MAX_VERT(MAX_VERT), .MAX_TRI(MAX_TRI)) u_cmd (
        .sck(sck), .rst(rst),
        .opcode_valid(opcode_valid), .opcode(opcode),
        .vert_hdr_valid(vert_hdr_valid), .vert_base(vert_base), .vert_count(vert_count),
        .vert_valid(vert_valid), .vert_in(vert_in),
        .tri_hdr_valid(tri_hdr_valid), .tri_base(tri_base), .tri_count(tri_count),
        .tri_valid(tri_valid), .tri_in(tri_in),
        .inst_valid(inst_valid), .inst_id_in(inst_id_in), .inst_in(inst_in),
        .transform_in(transform_in),
        .vert_we(vert_we), .vert_waddr(vert_waddr), .vert_wdata(vert_wdata),
        .tri_we(tri_we), .tri_waddr(tri_waddr), .tri_wdata(tri_wdata),
        .vdesc_we(vdesc_we), .tdesc_we(tdesc_we),
        .inst_we(inst_we), .inst_wdata(inst_wdata), .inst_raddr(inst_addr),
        .inst_rdata(inst_rmw),
        .status(status), .busy(busy)
    );

    scene_ram #(.DEPTH(MAX_VERT), .WIDTH($bits(vertex_t))) u_vert_ram (
        .sck(sck), .we(vert_we), .waddr(vert_waddr[VA_W-1:0]), .wdata(vert_wdata),
        .raddr_a('0), .rdata_a(),
        .raddr_b(vert_addr_rd[VA_W-1:0]), .rdata_b(vert_out)
    );

    scene_ram #(.DEPTH(MAX_TRI), .WIDTH($bits(tri_t))) u_tri_ram (
        .sck(sck), .we(tri_we), .waddr(tri_waddr[TA_W-1:0]), .wdata(tri_wdata),
        .raddr_a('0), .rdata_a(),
        .raddr_b(tri_addr_rd[TA_W-1:0]), .rdata_b(tri_out)
    );

    scene_ram #(.DEPTH(MAX_INST), .WIDTH($bits(inst_t))) u_inst_ram (
        .sck(sck), .we(inst_we), .waddr(inst_addr[IA_W-1:0]), .wdata(inst_wdata),
        .raddr_a(inst_addr[IA_W-1:0]), .rdata_a(inst_rmw),
        .raddr_b(inst_id_rd[IA_W-1:0]), .rdata_b(inst_rd)
    );

    desc_table #(.ENTRIES(MAX_BUF), .ADDR_W($bits(vaddr_t))) u_vert_desc (
        .sck(sck), .rst(rst), .we(vdesc_we),
        .wid(vert_id_in), .wbase(vert_base), .wcount(vert_count),
        .rid(rd_vert_id), .base(cur_vert_base), .count(cur_vert_count)
    );

    desc_table #(.ENTRIES(MAX_BUF), .ADDR_W($bits(taddr_t))) u_tri_desc (
        .sck(sck), .rst(rst), .we(tdesc_we),
        .wid(tri_id_in), .wbase(tri_base), .wcount(tri_count),
        .rid(rd_tri_id), .base(cur_tri_base), .count(cur_tri_count)
    );

endmodule

`default_nettype wire

// ==== hw/scene_pkg.sv ====
`default_nettype none

package scene_pkg;

    localparam int DATA_W  = 32;              // single precision float
    localparam int VTX_W   = 3*DATA_W + 3*4;  // xyz plus three 4 bit attributes
    localparam int TRANS_W = 9*DATA_W;        // 3x3 matrix
    localparam int VIDX_W  = 8;
    localparam int BUF_W   = 8;
    localparam int INST_W  = TRANS_W + 2*BUF_W;

    typedef logic [VTX_W-1:0]    vertex_t;
    typedef logic [VIDX_W-1:0]   vidx_t;
    typedef logic [3*VIDX_W-1:0] tri_t;    // corner 0 in the low bits
    typedef logic [TRANS_W-1:0]  transform_t;
    typedef logic [BUF_W-1:0]    buf_id_t;
    typedef logic [7:0]          inst_id_t;
    typedef logic [INST_W-1:0]   inst_t;   // {transform, vert id, tri id}
    typedef logic [7:0]          vaddr_t;
    typedef logic [7:0]          taddr_t;
    typedef logic [8:0]          count_t;  // 0 to 256

    typedef enum logic [3:0] {
        OP_WIPE = 4'd0,
        OP_VERT = 4'd1,
        OP_TRI  = 4'd2,
        OP_INST = 4'd3,
        OP_UPD  = 4'd4
    } opcode_t;

    typedef enum logic [3:0] {
        ST_OK       = 4'd0,
        ST_OVERFLOW = 4'd2,
        ST_BAD_OP   = 4'd3
    } status_t;

    typedef enum logic [2:0] {
        IDLE,
        VERT_HDR,
        VERT_DATA,
        TRI_HDR,
        TRI_DATA,
        INST_WR,
        UPD_RD,     // fetch stored ids
        UPD_WR      // write new transform with old ids
    } cmd_state_t;

endpackage

`default_nettype wire

// ==== hw/scene_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_ram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 32
) (
    input  wire logic                     sck,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] waddr,
    input  wire logic [WIDTH-1:0]         wdata,
    input  wire logic [$clog2(DEPTH)-1:0] raddr_a,
    output logic      [WIDTH-1:0]         rdata_a,
    input  wire logic [$clog2(DEPTH)-1:0] raddr_b,
    output logic      [WIDTH-1:0]         rdata_b
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge sck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata_a <= mem[raddr_a];  // read first, old word on collision
        rdata_b <= mem[raddr_b];
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/scene_pkg.sv
hw/scene_ram.sv
hw/desc_table.sv
hw/scene_cmd_fsm.sv
hw/scene_mem.sv
test/scene_mem_checker.sv
test/scene_mem_tb.sv

// ==== test/scene_mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_mem_checker import scene_pkg::*; #(
    parameter int MAX_VERT = 256,
    parameter int MAX_TRI  = 256
) (
    input wire logic       sck,
    input wire logic       rst,
    input wire logic       busy,
    input wire logic       opcode_valid,
    input wire logic [3:0] opcode,
    input wire logic       vert_hdr_valid,
    input wire vaddr_t     vert_base,
    input wire count_t     vert_count,
    input wire logic       tri_hdr_valid,
    input wire taddr_t     tri_base,
    input wire count_t     tri_count,
    input wire logic       vert_we,
    input wire vaddr_t     vert_waddr,
    input wire logic       tri_we,
    input wire taddr_t     tri_waddr,
    input wire logic [3:0] status
);

    int         n_fail = 0;
    logic       op_unknown;
    logic [9:0] next_addr;  // unwrapped, a run past the top shows up
    count_t     left;       // writes still due in the run

    assign op_unknown = opcode_valid && !busy &&
                        !(opcode inside {OP_WIPE, OP_VERT, OP_TRI, OP_INST, OP_UPD});

    always_ff @(posedge sck) begin
        if (rst) begin
            next_addr <= '0;
            left      <= '0;
        end else if (vert_hdr_valid) begin
            next_addr <= 10'(vert_base);
            left      <= vert_count;
        end else if (tri_hdr_valid) begin
            next_addr <= 10'(tri_base);
            left      <= tri_count;
        end else if (vert_we || tri_we) begin
            next_addr <= next_addr + 10'd1;
            left      <= left - 9'd1;
        end
    end

    // busy falls on the edge of the last write, not before
    a_busy_end: assert property (@(posedge sck) disable iff (rst)
        (vert_we || tri_we) |=> busy == (left != '0))
        else begin
            n_fail++;
            $error("busy out of step with the write count");
        end

    a_vert_range: assert property (@(posedge sck) disable iff (rst)
        vert_we |-> 10'(vert_waddr) == next_addr && next_addr < 10'(MAX_VERT))
        else begin
            n_fail++;
            $error("vertex write off its buffer or beyond RAM");
        end

    a_tri_range: assert property (@(posedge sck) disable iff (rst)
        tri_we |-> 10'(tri_waddr) == next_addr && next_addr < 10'(MAX_TRI))
        else begin
            n_fail++;
            $error("triangle write off its buffer or beyond RAM");
        end

    a_bad_op_idle: assert property (@(posedge sck) disable iff (rst)
        op_unknown |=> !busy)
        else begin
            n_fail++;
            $error("busy rose after unknown opcode");
        end

    // status only moves when a command ends
    a_status_hold: assert property (@(posedge sck) disable iff (rst)
        busy |-> $stable(status))
        else begin
            n_fail++;
            $error("status changed while a command ran");
        end

endmodule

bind scene_mem scene_mem_checker #(.MAX_VERT(MAX_VERT), .MAX_TRI(MAX_TRI)) u_checker (
    .sck(sck), .rst(rst), .busy(busy), .opcode_valid(opcode_valid), .opcode(opcode),
    .vert_hdr_valid(vert_hdr_valid), .vert_base(vert_base), .vert_count(vert_count),
    .tri_hdr_valid(tri_hdr_valid), .tri_base(tri_base), .tri_count(tri_count),
    .vert_we(vert_we), .vert_waddr(vert_waddr), .tri_we(tri_we), .tri_waddr(tri_waddr),
    .status(status)
);

`default_nettype wire

// ==== test/scene_mem_stimulus.txt ====
# C opcode id base count | V vertex | T triangle | I inst_id payload | S status (all hex)
# R V addr vertex | R T addr triangle | R I inst_id transform vbase vcount tbase tcount
C 1 01 0a 004
V 3f8000000000000000000000123
V 000000003f80000000000000456
V 00000000000000003f800000789
V 3f8000003f8000003f800000abc
S 0
R V 0a 3f8000000000000000000000123
R V 0b 000000003f80000000000000456
R V 0c 00000000000000003f800000789
R V 0d 3f8000003f8000003f800000abc
C 2 02 14 003
T 020100
T 030201
T 000302
S 0
C 2 03 28 002
T 010203
T 020301
S 0
R T 14 020100
R T 15 030201
R T 16 000302
R T 28 010203
R T 29 020301
C 3 00 00 000
I 05 3f800000000000003f8000000102
S 0
R I 05 3f800000000000003f800000 0a 004 14 003
C 4 00 00 000
I 05 4000000000000000bf800000
S 0
R I 05 4000000000000000bf800000 0a 004 14 003
C 1 01 fa 00a
S 2
R V 0a 3f8000000000000000000000123
R V 0d 3f8000003f8000003f800000abc
R I 05 4000000000000000bf800000 0a 004 14 003
C 9 00 00 000
S 3
C 0 00 00 000
S 0

// ==== test/scene_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_mem_tb import scene_pkg::*; ();

    localparam string STIM_FILE = "test/scene_mem_stimulus.txt";

    logic       sck;
    logic       rst;
    logic       opcode_valid;
    opcode_t    opcode;
    logic       vert_hdr_valid;
    buf_id_t    vert_id_in;
    vaddr_t     vert_base;
    count_t     vert_count;
    logic       vert_valid;
    vertex_t    vert_in;
    logic       tri_hdr_valid;
    buf_id_t    tri_id_in;
    taddr_t     tri_base;
    count_t     tri_count;
    logic       tri_valid;
    tri_t       tri_in;
    logic       inst_valid;
    inst_id_t   inst_id_in;
    inst_t      inst_in;
    transform_t transform_in;
    inst_id_t   inst_id_rd;
    vaddr_t     vert_addr_rd;
    taddr_t     tri_addr_rd;
    status_t    status;
    logic       busy;
    vertex_t    vert_out;
    tri_t       tri_out;
    transform_t transform_out;
    vaddr_t     cur_vert_base;
    count_t     cur_vert_count;
    taddr_t     cur_tri_base;
    count_t     cur_tri_count;

    integer seed = 83262;
    int     n_records = 0;  // sizes the watchdog
    int     n_checks = 0;

    scene_mem i_scene_mem (.*);

    initial begin
        sck = 1'b0;
        forever #20 sck = ~sck;
    end

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [511:0] exp,
                                   input logic [511:0] act);
        $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        abort_run("output value differs from expected value");
    endtask

    task automatic check_vertex(input string name, input vertex_t exp, input vertex_t act);
        if (act !== exp) report_mismatch(name, exp, act);
        else n_checks++;
    endtask

    task automatic check_tri(input string name, input tri_t exp, input tri_t act);
        if (act !== exp) report_mismatch(name, exp, act);
        else n_checks++;
    endtask

    task automatic check_transform(input string name, input transform_t exp,
                                   input transform_t act);
        if (act !== exp) report_mismatch(name, exp, act);
        else n_checks++;
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) report_mismatch(name, exp, act);
        else n_checks++;
    endtask

    task automatic check_addr(input string name, input vaddr_t exp, input vaddr_t act);
        if (act !== exp) report_mismatch(name, exp, act);
        else n_checks++;
    endtask

    task automatic check_status(input string name, input status_t exp, input status_t act);
        if (act !== exp) report_mismatch(name, exp, act);
        else n_checks++;
    endtask

    task automatic expect_fields(input int got, input int want);
        if (got != want) abort_run("malformed record in stimulus file");
    endtask

    task automatic idle_gap();
        repeat ({$random(seed)} % 4) @(posedge sck);  // 0 to 3 idle cycles
    endtask

    task automatic send_command(input logic [3:0] op, input buf_id_t id,
                                input vaddr_t base, input count_t cnt);
        @(posedge sck);
        opcode_valid   <= 1'b1;
        opcode         <= opcode_t'(op);
        @(posedge sck);
        opcode_valid   <= 1'b0;
        vert_id_in     <= id;
        vert_base      <= base;
        vert_count     <= cnt;
        tri_id_in      <= id;
        tri_base       <= base;
        tri_count      <= cnt;
        vert_hdr_valid <= (op == OP_VERT);  // header follows the opcode
        tri_hdr_valid  <= (op == OP_TRI);
        @(posedge sck);
        vert_hdr_valid <= 1'b0;
        tri_hdr_valid  <= 1'b0;
    endtask

    task automatic send_vertex(input vertex_t v);
        idle_gap();
        @(posedge sck);
        vert_valid <= 1'b1;
        vert_in    <= v;
        @(posedge sck);
        vert_valid <= 1'b0;
    endtask

    task automatic send_tri(input tri_t t);
        idle_gap();
        @(posedge sck);
        tri_valid <= 1'b1;
        tri_in    <= t;
        @(posedge sck);
        tri_valid <= 1'b0;
    endtask

    task automatic send_inst(input inst_id_t id, input inst_t payload);
        idle_gap();
        @(posedge sck);
        inst_valid   <= 1'b1;
        inst_id_in   <= id;
        inst_in      <= payload;
        transform_in <= payload[TRANS_W-1:0];  // update record carries a bare transform
        @(posedge sck);
        inst_valid   <= 1'b0;
    endtask

    task automatic expect_status(input status_t exp);
        @(negedge sck);
        while (busy) @(negedge sck);
        check_status("status", exp, status);
    endtask

    task automatic read_vertex(input vaddr_t addr, input vertex_t exp);
        @(posedge sck);
        vert_addr_rd <= addr;
        @(posedge sck);
        @(negedge sck);
        check_vertex("vert_out", exp, vert_out);
    endtask

    task automatic read_tri(input taddr_t addr, input tri_t exp);
        @(posedge sck);
        tri_addr_rd <= addr;
        @(posedge sck);
        @(negedge sck);
        check_tri("tri_out", exp, tri_out);
    endtask

    task automatic read_inst(input inst_id_t id, input transform_t exp_trans,
                             input vaddr_t vb, input count_t vc,
                             input taddr_t tb, input count_t tc);
        @(posedge sck);
        inst_id_rd <= id;
        @(posedge sck);
        @(negedge sck);
        check_transform("transform_out", exp_trans, transform_out);
        check_addr("cur_vert_base", vb, cur_vert_base);
        check_count("cur_vert_count", vc, cur_vert_count);
        check_addr("cur_tri_base", tb, cur_tri_base);
        check_count("cur_tri_count", tc, cur_tri_count);
    endtask

    initial begin
        int               fd;
        int               code;
        byte              tag;
        byte              kind;
        logic [3:0]       f_op;
        buf_id_t          f_id;
        vaddr_t           f_addr;
        vaddr_t           f_vb;
        count_t           f_vc;
        taddr_t           f_tb;
        count_t           f_tc;
        inst_t            f_wide;
        logic [8*128-1:0] line;

        rst            <= 1'b1;
        opcode_valid   <= 1'b0;
        opcode         <= OP_WIPE;
        vert_hdr_valid <= 1'b0;
        vert_id_in     <= '0;
        vert_base      <= '0;
        vert_count     <= '0;
        vert_valid     <= 1'b0;
        vert_in        <= '0;
        tri_hdr_valid  <= 1'b0;
        tri_id_in      <= '0;
        tri_base       <= '0;
        tri_count      <= '0;
        tri_valid      <= 1'b0;
        tri_in         <= '0;
        inst_valid     <= 1'b0;
        inst_id_in     <= '0;
        inst_in        <= '0;
        transform_in   <= '0;
        inst_id_rd     <= '0;
        vert_addr_rd   <= '0;
        tri_addr_rd    <= '0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) abort_run("cannot open the stimulus file");
        while ($fscanf(fd, " %c", tag) == 1) begin  // first pass counts records
            code = $fgets(line, fd);
            if (tag != "#") n_records++;
        end
        $fclose(fd);

        repeat (10) @(posedge sck);
        rst <= 1'b0;

        fd = $fopen(STIM_FILE, "r");
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": code = $fgets(line, fd);
                "C": begin
                    code = $fscanf(fd, "%h %h %h %h", f_op, f_id, f_addr, f_vc);
                    expect_fields(code, 4);
                    send_command(f_op, f_id, f_addr, f_vc);
                end
                "V": begin
                    code = $fscanf(fd, "%h", f_wide);
                    expect_fields(code, 1);
                    send_vertex(f_wide[VTX_W-1:0]);
                end
                "T": begin
                    code = $fscanf(fd, "%h", f_wide);
                    expect_fields(code, 1);
                    send_tri(f_wide[$bits(tri_t)-1:0]);
                end
                "I": begin
                    code = $fscanf(fd, "%h %h", f_id, f_wide);
                    expect_fields(code, 2);
                    send_inst(f_id, f_wide);
                end
                "S": begin
                    code = $fscanf(fd, "%h", f_op);
                    expect_fields(code, 1);
                    expect_status(status_t'(f_op));
                end
                "R": begin
                    code = $fscanf(fd, " %c %h", kind, f_addr);
                    expect_fields(code, 2);
                    if (kind == "V") begin
                        code = $fscanf(fd, "%h", f_wide);
                        expect_fields(code, 1);
                        read_vertex(f_addr, f_wide[VTX_W-1:0]);
                    end else if (kind == "T") begin
                        code = $fscanf(fd, "%h", f_wide);
                        expect_fields(code, 1);
                        read_tri(f_addr, f_wide[$bits(tri_t)-1:0]);
                    end else if (kind == "I") begin
                        code = $fscanf(fd, "%h %h %h %h %h", f_wide, f_vb, f_vc, f_tb, f_tc);
                        expect_fields(code, 5);
                        read_inst(f_addr, f_wide[TRANS_W-1:0], f_vb, f_vc, f_tb, f_tc);
                    end else begin
                        abort_run("unknown read kind in stimulus file");
                    end
                end
                default: abort_run("unknown record tag in stimulus file");
            endcase
        end
        $fclose(fd);

        if (n_checks == 0) begin
            abort_run("the stimulus file held no checks");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    initial begin
        wait (i_scene_mem.u_checker.n_fail != 0);
        abort_run("an assertion in the bound checker failed");
    end

    // 200 cycles per record plus reset
    initial begin
        wait (n_records > 0);
        repeat (200 * n_records + 10) @(posedge sck);
        abort_run("watchdog timeout, the run took longer than the stimulus allows");
    end

endmodule

`default_nettype wire
